// File: ocpMasterTop.f
+incdir+design
design/ocpBusPkg.sv
design/bridgePkg.sv
design/burstAddressGen.sv
design/requestSequencer.sv
design/responseCapture.sv
design/ocpMasterTop.sv
sim/ocpSlaveModel.sv
sim/ocpMasterTb.sv

// File: runSim.sh
#!/bin/sh
# Build with Verilator and run, the exit status is the verdict
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module ocpMasterTb -f ocpMasterTop.f \
  && ./obj_dir/VocpMasterTb \
  || exit 1

// File: sim/ocpMasterTb.sv
// Testbench for ocpMasterTop against the behavioral OCP slave
// Table rows run one burst at a time
// Memory model keyed by low address byte
module ocpMasterTb import ocpBusPkg::*, bridgePkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // Stimulus plus the status every beat must report
  typedef struct packed {
    logic     isWrite;
    ocpAddrT  address;
    burstLenT length;
    burstSeqE burstSeq;
    ocpDataT  dataSeed;
    sRespE    expStatus;
  } tableRowT;

  localparam int numRows = 8;

  logic         Clk = 1'b0;
  logic         reset;
  bridgeReqT    bridgeReq;
  logic         reqValid;
  logic         reqReady;
  ocpDataT      wrData;
  logic         wrDataTake;
  readResultT   readResult;
  logic         rdValid;
  ocpReqT       ocpReq;
  logic         SCmdAccept;
  ocpRspT       ocpRsp;
  tableRowT     stimTable [0:numRows-1];
  // Expected slave memory
  ocpDataT      refMem [0:255];
  logic [255:0] refWritten;
  int           cycleCount = 0;
  int           cycleLimit = 100;
  int           totalBeats;

  always #50 Clk = ~Clk;

  ocpMasterTop ocpMasterTop_inst (
    .Clk        (Clk),
    .reset      (reset),
    .bridgeReq  (bridgeReq),
    .reqValid   (reqValid),
    .reqReady   (reqReady),
    .wrData     (wrData),
    .wrDataTake (wrDataTake),
    .readResult (readResult),
    .rdValid    (rdValid),
    .ocpReq     (ocpReq),
    .SCmdAccept (SCmdAccept),
    .ocpRsp     (ocpRsp)
  );

  ocpSlaveModel ocpSlaveModel_inst (
    .Clk        (Clk),
    .reset      (reset),
    .ocpReq     (ocpReq),
    .SCmdAccept (SCmdAccept),
    .ocpRsp     (ocpRsp)
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    assert (got == exp) else
      failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // INCR steps one byte per beat and STRM stays put
  function automatic ocpAddrT beatAddrOf(input tableRowT row, input int k);
    if (row.burstSeq == seqIncr) begin
      return row.address + ocpAddrT'(k);
    end else begin
      return row.address;
    end
  endfunction

  function automatic ocpDataT expectedRead(input ocpAddrT addr);
    if (refWritten[addr[7:0]]) begin
      return refMem[addr[7:0]];
    end else begin
      return addr[7:0] ^ 8'h5A;
    end
  endfunction

  task automatic runRow(input tableRowT row);
    ocpReqT  prevReq;
    ocpReqT  beat;
    logic    prevWaiting;
    logic    lastSeen;
    logic    checkIdle;
    int      takeCount;
    int      resultCount;
    int      logStart;
    ocpAddrT addr;
    ocpDataT expData;
    prevReq     = '0;
    prevWaiting = 1'b0;
    lastSeen    = 1'b0;
    checkIdle   = 1'b0;
    takeCount   = 0;
    resultCount = 0;
    while (!reqReady) begin
      @(posedge Clk);
    end
    logStart  = ocpSlaveModel_inst.beatCount;
    // First word goes out together with the request
    bridgeReq <= '{row.isWrite, row.address, row.length, row.burstSeq};
    wrData    <= row.dataSeed;
    reqValid  <= 1'b1;
    @(posedge Clk);
    reqValid <= 1'b0;
    // Request taken on this edge
    // Follow the burst until every beat has a result
    while (resultCount < int'(row.length)) begin
      @(posedge Clk);
      if (prevWaiting) begin
        assert (ocpReq == prevReq) else failRun($sformatf(
          "[ERROR] ocpReq: 0x%h changed to 0x%h before accept", prevReq, ocpReq));
      end
      if (checkIdle) begin
        checkValue("MCmd", 64'(ocpReq.MCmd), 64'(cmdIdle));
        checkValue("reqReady", 64'(reqReady), 64'd1);
        checkIdle = 1'b0;
      end else if (!lastSeen) begin
        checkValue("reqReady", 64'(reqReady), 64'd0);
      end
      if ((ocpReq.MCmd != cmdIdle) && SCmdAccept && ocpReq.MReqLast) begin
        lastSeen  = 1'b1;
        checkIdle = 1'b1;
      end
      prevWaiting = (ocpReq.MCmd != cmdIdle) && !SCmdAccept;
      prevReq     = ocpReq;
      // Next word appears one edge after each pulse
      if (wrDataTake) begin
        takeCount++;
        wrData <= row.dataSeed + ocpDataT'(takeCount);
      end
      if (rdValid) begin
        addr = beatAddrOf(row, resultCount);
        checkValue("readResult.status", 64'(readResult.status), 64'(row.expStatus));
        if (!row.isWrite) begin
          expData = (row.expStatus == respErr) ? 8'h00 : expectedRead(addr);
          checkValue("readResult.data", 64'(readResult.data), 64'(expData));
        end
        resultCount++;
      end
    end
    checkValue("wrDataTake pulses", 64'(takeCount), 64'(row.isWrite ? int'(row.length) : 0));
    checkValue("accepted beats", 64'(ocpSlaveModel_inst.beatCount - logStart),
               64'(row.length));
    // Beats as the slave saw them
    for (int k = 0; k < int'(row.length); k++) begin
      beat = ocpSlaveModel_inst.beatLog[6'(logStart + k)];
      addr = beatAddrOf(row, k);
      checkValue("MCmd", 64'(beat.MCmd), 64'(row.isWrite ? cmdWr : cmdRd));
      checkValue("MAddr", beat.MAddr, addr);
      checkValue("MBurstLength", 64'(beat.MBurstLength), 64'(row.length));
      checkValue("MBurstSeq", 64'(beat.MBurstSeq), 64'(row.burstSeq));
      checkValue("MReqLast", 64'(beat.MReqLast), 64'(k == int'(row.length) - 1));
      if (row.isWrite) begin
        checkValue("MData", 64'(beat.MData), 64'(row.dataSeed + ocpDataT'(k)));
        if (row.expStatus == respDva) begin
          refMem[addr[7:0]]     = row.dataSeed + ocpDataT'(k);
          refWritten[addr[7:0]] = 1'b1;
        end
      end
    end
    if (row.isWrite && (row.expStatus == respDva)) begin
      for (int k = 0; k < int'(row.length); k++) begin
        addr = beatAddrOf(row, k);
        checkValue("slave mem", 64'(ocpSlaveModel_inst.mem[addr[7:0]]),
                   64'(refMem[addr[7:0]]));
      end
    end
  endtask

  // Run limit grows with the table
  always @(posedge Clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      failRun($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
    end
  end

  initial begin
    reset      = 1'b1;
    reqValid   = 1'b0;
    bridgeReq  = '0;
    wrData     = '0;
    refWritten = '0;
    // Single write and an INCR read of it
    stimTable[0] = '{1'b1, 64'h10, 10'd1, seqIncr, 8'hA5, respDva};
    stimTable[1] = '{1'b0, 64'h10, 10'd4, seqIncr, 8'h00, respDva};
    // STRM keeps hitting one byte
    stimTable[2] = '{1'b1, 64'h20, 10'd3, seqStrm, 8'h31, respDva};
    stimTable[3] = '{1'b0, 64'h20, 10'd2, seqStrm, 8'h00, respDva};
    stimTable[4] = '{1'b0, 64'hF004, 10'd1, seqIncr, 8'h00, respErr};
    stimTable[5] = '{1'b1, 64'h40, 10'd3, seqIncr, 8'h70, respDva};
    stimTable[6] = '{1'b0, 64'h40, 10'd3, seqIncr, 8'h00, respDva};
    stimTable[7] = '{1'b1, 64'hF100, 10'd2, seqIncr, 8'h11, respErr};
    totalBeats = 0;
    for (int i = 0; i < numRows; i++) begin
      totalBeats += int'(stimTable[i].length);
    end
    cycleLimit = 40 * totalBeats + 100;
    repeat (5) @(posedge Clk);
    reset <= 1'b0;
    @(posedge Clk);
    // Quiet outputs straight out of reset
    checkValue("MCmd", 64'(ocpReq.MCmd), 64'(cmdIdle));
    checkValue("MReqLast", 64'(ocpReq.MReqLast), 64'd0);
    checkValue("reqReady", 64'(reqReady), 64'd1);
    checkValue("rdValid", 64'(rdValid), 64'd0);
    checkValue("wrDataTake", 64'(wrDataTake), 64'd0);
    for (int i = 0; i < numRows; i++) begin
      runRow(stimTable[i]);
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: sim/ocpSlaveModel.sv
// Behavioral OCP slave, 256-byte memory indexed by the low address byte
// Accept delay of 0 to 3 cycles per beat, ERR at 64'hF000 and above
module ocpSlaveModel import ocpBusPkg::*; (
  input  logic   Clk,
  input  logic   reset,
  input  ocpReqT ocpReq,
  output logic   SCmdAccept,
  output ocpRspT ocpRsp
);
  timeunit 1ns;
  timeprecision 1ps;

  ocpDataT      mem [0:255];
  logic [255:0] written;
  // Every accepted beat in order
  ocpReqT       beatLog [0:63];
  int           beatCount;
  integer       seed = 38;
  // Cycles left before the current beat is taken
  logic [1:0]   waitCnt;
  logic [7:0]   idx;
  logic         errRegion;

  assign SCmdAccept = (ocpReq.MCmd != cmdIdle) && (waitCnt == 2'd0);
  assign idx        = ocpReq.MAddr[7:0];
  assign errRegion  = (ocpReq.MAddr >= 64'hF000);

  always @(posedge Clk) begin
    integer draw;
    draw = $random(seed);
    if (reset) begin
      waitCnt   <= draw[1:0];
      beatCount <= 0;
      written   <= '0;
      ocpRsp    <= '{respNull, 8'h00};
    end else if (SCmdAccept) begin
      // Fresh delay for the beat after this one
      waitCnt                 <= draw[1:0];
      beatLog[beatCount[5:0]] <= ocpReq;
      beatCount               <= beatCount + 1;
      if (errRegion) begin
        // Nonzero data, the master has to clear it
        ocpRsp <= '{respErr, 8'hEE};
      end else if (ocpReq.MCmd == cmdWr) begin
        mem[idx]     <= ocpReq.MData;
        written[idx] <= 1'b1;
        ocpRsp       <= '{respDva, 8'h00};
      end else begin
        // Unwritten bytes read back a pattern of their address
        ocpRsp <= '{respDva, written[idx] ? mem[idx] : (idx ^ 8'h5A)};
      end
    end else begin
      ocpRsp <= '{respNull, 8'h00};
      if ((ocpReq.MCmd != cmdIdle) && (waitCnt != 2'd0)) begin
        waitCnt <= waitCnt - 2'd1;
      end
    end
  end

endmodule

// File: design/ocpMasterTop.sv
// OCP 2.2 master, bridge requests in and single or burst commands out
// No MRespAccept, every response is taken; no clock enable
module ocpMasterTop import ocpBusPkg::*, bridgePkg::*; (
  input  logic       Clk,
  input  logic       reset,
  input  bridgeReqT  bridgeReq,
  input  logic       reqValid,
  output logic       reqReady,
  input  ocpDataT    wrData,
  output logic       wrDataTake,
  output readResultT readResult,
  output logic       rdValid,
  output ocpReqT     ocpReq,
  input  logic       SCmdAccept,
  input  ocpRspT     ocpRsp
);

  // Request path toward the bus
  requestSequencer requestSequencer_inst (
    .Clk        (Clk),
    .reset      (reset),
    .bridgeReq  (bridgeReq),
    .reqValid   (reqValid),
    .reqReady   (reqReady),
    .wrData     (wrData),
    .wrDataTake (wrDataTake),
    .SCmdAccept (SCmdAccept),
    .ocpReq     (ocpReq)
  );

  // Response path back to the bridge
  responseCapture responseCapture_inst (
    .Clk        (Clk),
    .reset      (reset),
    .ocpRsp     (ocpRsp),
    .readResult (readResult),
    .rdValid    (rdValid)
  );

endmodule

// File: design/responseCapture.sv
// Registers each slave response into a bridge result one cycle later
// Responses are always accepted, so back to back ones each get a cycle
module responseCapture import ocpBusPkg::*, bridgePkg::*; (
  input  logic       Clk,
  input  logic       reset,
  input  ocpRspT     ocpRsp,
  output readResultT readResult,
  output logic       rdValid
);

  // Response group valid whenever SResp is not NULL
  logic rspPresent;

  assign rspPresent = (ocpRsp.SResp != respNull);

  // Valid flag
  always_ff @(posedge Clk) begin
    if (reset) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rspPresent;
    end
  end

  // Result payload, held between responses
  always_ff @(posedge Clk) begin
    if (rspPresent) begin
      readResult.status <= ocpRsp.SResp;
      // DVA and FAIL carry data, ERR does not
      if (ocpRsp.SResp == respErr) begin
        readResult.data <= '0;
      end else begin
        readResult.data <= ocpRsp.SData;
      end
    end
  end

endmodule

// File: design/requestSequencer.sv
// Issues bridge requests as OCP bursts, one beat held until SCmdAccept
// Write beats after the first wait two idle cycles for the next bridge word
module requestSequencer import ocpBusPkg::*, bridgePkg::*; (
  input  logic      Clk,
  input  logic      reset,
  input  bridgeReqT bridgeReq,
  input  logic      reqValid,
  output logic      reqReady,
  input  ocpDataT   wrData,
  output logic      wrDataTake,
  input  logic      SCmdAccept,
  output ocpReqT    ocpReq
);

  typedef enum logic [1:0] {stIdle, stWrite, stRead} seqStateE;

  seqStateE state;
  mCmdE     cmdReg;
  ocpDataT  dataReg;
  burstLenT lenReg;
  burstSeqE seqReg;
  // Countdown while the bridge brings the next write word
  logic [1:0] fetchWait;
  ocpAddrT  beatAddr;
  logic     lastBeat;
  logic     take;
  logic     accepted;

  // Only one burst at a time
  assign reqReady = (state == stIdle);
  assign take     = reqValid && reqReady;
  // Beat on the bus sampled with SCmdAccept
  assign accepted = (cmdReg != cmdIdle) && SCmdAccept;

  burstAddressGen burstAddressGen_inst (
    .Clk       (Clk),
    .reset     (reset),
    .load      (take),
    .step      (accepted),
    .startAddr (bridgeReq.address),
    .length    (bridgeReq.length),
    .burstSeq  (bridgeReq.burstSeq),
    .beatAddr  (beatAddr),
    .lastBeat  (lastBeat)
  );

  // Command FSM
  always_ff @(posedge Clk) begin
    if (reset) begin
      state      <= stIdle;
      cmdReg     <= cmdIdle;
      fetchWait  <= 2'd0;
      wrDataTake <= 1'b0;
    end else begin
      // Ask for a new word after every accepted write beat
      wrDataTake <= accepted && (state == stWrite);
      case (state)
        stIdle: begin
          if (take) begin
            state  <= bridgeReq.isWrite ? stWrite : stRead;
            cmdReg <= bridgeReq.isWrite ? cmdWr : cmdRd;
          end
        end
        stWrite: begin
          if (accepted && lastBeat) begin
            state  <= stIdle;
            cmdReg <= cmdIdle;
          end else if (accepted) begin
            // Bus idle until the word behind wrDataTake shows up
            cmdReg    <= cmdIdle;
            fetchWait <= 2'd2;
          end else if (fetchWait == 2'd1) begin
            cmdReg    <= cmdWr;
            fetchWait <= 2'd0;
          end else if (fetchWait != 2'd0) begin
            fetchWait <= fetchWait - 2'd1;
          end
        end
        stRead: begin
          // Read beats go back to back
          if (accepted && lastBeat) begin
            state  <= stIdle;
            cmdReg <= cmdIdle;
          end
        end
        default: begin
          state  <= stIdle;
          cmdReg <= cmdIdle;
        end
      endcase
    end
  end

  // Latched request fields and beat data
  always_ff @(posedge Clk) begin
    if (take) begin
      lenReg  <= bridgeReq.length;
      seqReg  <= bridgeReq.burstSeq;
      // First word is already valid with the request
      dataReg <= bridgeReq.isWrite ? wrData : '0;
    end else if ((state == stWrite) && (fetchWait == 2'd1)) begin
      dataReg <= wrData;
    end
  end

  // Request group straight from registers
  always_comb begin
    ocpReq.MCmd         = cmdReg;
    ocpReq.MAddr        = beatAddr;
    ocpReq.MData        = dataReg;
    ocpReq.MBurstLength = lenReg;
    ocpReq.MBurstSeq    = seqReg;
    ocpReq.MReqLast     = lastBeat;
  end

  // Beat held unchanged until accepted
  beatStable: assert property (@(posedge Clk) disable iff (reset)
    ((ocpReq.MCmd != cmdIdle) && !SCmdAccept) |=> $stable(ocpReq));

  // Bridge must send a nonzero length and a supported sequence
  reqLegal: assert property (@(posedge Clk) disable iff (reset)
    take |-> ((bridgeReq.length != '0) &&
              ((bridgeReq.burstSeq == seqIncr) || (bridgeReq.burstSeq == seqStrm))));

endmodule

// File: design/burstAddressGen.sv
// Beat address and last-beat flag of the burst on the bus
// INCR steps one byte per beat, STRM holds, other sequences hold too
module burstAddressGen import ocpBusPkg::*; (
  input  logic     Clk,
  input  logic     reset,
  input  logic     load,
  input  logic     step,
  input  ocpAddrT  startAddr,
  input  burstLenT length,
  input  burstSeqE burstSeq,
  output ocpAddrT  beatAddr,
  output logic     lastBeat
);

  // Accepted beats so far in this burst
  burstLenT beatCount;
  burstLenT lenReg;
  burstSeqE seqReg;
  // Set once the final beat has been stepped
  logic     passedLast;

  // Counter and flags
  always_ff @(posedge Clk) begin
    if (reset) begin
      beatCount  <= '0;
      lastBeat   <= 1'b0;
      passedLast <= 1'b0;
    end else if (load) begin
      beatCount  <= '0;
      // Single beat burst is last right away
      lastBeat   <= (length == burstLenT'(1));
      passedLast <= 1'b0;
    end else if (step) begin
      beatCount  <= beatCount + burstLenT'(1);
      // Next beat is last when its index hits length minus one
      lastBeat   <= ((beatCount + burstLenT'(1)) == (lenReg - burstLenT'(1)));
      passedLast <= passedLast | lastBeat;
    end
  end

  // Address and latched burst shape
  always_ff @(posedge Clk) begin
    if (load) begin
      beatAddr <= startAddr;
      lenReg   <= length;
      seqReg   <= burstSeq;
    end else if (step && (seqReg == seqIncr)) begin
      beatAddr <= beatAddr + ocpAddrT'(1);
    end
  end

  // No beat may be accepted once the burst is complete
  stepAfterLast: assert property (@(posedge Clk) disable iff (reset)
    step |-> !passedLast);

endmodule

// File: design/bridgePkg.sv
// Bridge side request and result formats
// Length counts beats and must be nonzero
`include "ocpMaster_defines.svh"

package bridgePkg;
  import ocpBusPkg::*;

  // One request from the bridge
  // Write data is not part of it, it comes per beat on wrData
  typedef struct packed {
    logic     isWrite;
    ocpAddrT  address;
    burstLenT length;
    burstSeqE burstSeq;
  } bridgeReqT;

  // Outcome of one beat, reads and writes alike
  // Data is zero when status is ERR
  typedef struct packed {
    sRespE   status;
    ocpDataT data;
  } readResultT;

endpackage

// File: design/ocpBusPkg.sv
// OCP 2.2 encodings and signal groups of the master profile
// No simple, tag, thread, sideband or test groups in this profile
`include "ocpMaster_defines.svh"

package ocpBusPkg;

  // Meaningful widths
  typedef logic [`OCP_ADDR_WIDTH-1:0] ocpAddrT;
  typedef logic [`OCP_DATA_WIDTH-1:0] ocpDataT;
  typedef logic [`OCP_BURST_WIDTH-1:0] burstLenT;

  // MCmd codes, only idle, write and read get issued
  typedef enum logic [2:0] {
    cmdIdle = 3'b000,
    cmdWr   = 3'b001,
    cmdRd   = 3'b010,
    cmdRdex = 3'b011,
    cmdRdl  = 3'b100,
    cmdWrnp = 3'b101,
    cmdWrc  = 3'b110,
    cmdBcst = 3'b111
  } mCmdE;

  // SResp codes
  typedef enum logic [1:0] {
    respNull = 2'b00,
    respDva  = 2'b01,
    respFail = 2'b10,
    respErr  = 2'b11
  } sRespE;

  // MBurstSeq codes
  // Master supports INCR and STRM only
  typedef enum logic [2:0] {
    seqIncr  = 3'b000,
    seqDflt1 = 3'b001,
    seqWrap  = 3'b010,
    seqDflt2 = 3'b011,
    seqXor   = 3'b100,
    seqStrm  = 3'b101,
    seqUnkn  = 3'b110,
    seqBlck  = 3'b111
  } burstSeqE;

  // Request group, master to slave
  typedef struct packed {
    mCmdE     MCmd;
    ocpAddrT  MAddr;
    ocpDataT  MData;
    burstLenT MBurstLength;
    burstSeqE MBurstSeq;
    logic     MReqLast;
  } ocpReqT;

  // Response group, slave to master
  // Present whenever SResp is not NULL
  typedef struct packed {
    sRespE   SResp;
    ocpDataT SData;
  } ocpRspT;

endpackage

// File: design/ocpMaster_defines.svh
// Widths of the shrunk OCP 2.2 profile
// Byte-wide data, so an INCR burst steps the address by one per beat
`ifndef OCP_MASTER_DEFINES_SVH
`define OCP_MASTER_DEFINES_SVH

// Byte address of the OCP bus
`define OCP_ADDR_WIDTH 64

// One data word per beat
`define OCP_DATA_WIDTH 8

// MBurstLength field, beats per burst
// Zero is not a legal length
`define OCP_BURST_WIDTH 10

`endif
